// File: files.f
+incdir+bench
hw/md5_pkg.sv
hw/md5_stage_if.sv
hw/md5_block_loader.sv
hw/md5_round.sv
hw/md5_digest_adder.sv
hw/md5_core.sv
bench/tb_md5_core.sv

// File: Makefile
# Verilator build and run for the MD5 core testbench

VERILATOR ?= verilator
TOP       ?= tb_md5_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard bench/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: bench/md5_model.svh
////////////////////////////////////////
// Reference model of MD5 on one padded block
// Own sine table, shift and index rules
////////////////////////////////////////

`ifndef MD5_MODEL_SVH
`define MD5_MODEL_SVH

localparam logic [31:0] MODEL_T [0:63] = '{
	32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
	32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
	32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
	32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
	32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
	32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
	32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
	32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
	32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
	32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
	32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
	32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
	32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
	32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
	32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
	32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
};

// Digest as {A, B, C, D}, word 0 of the block in the low bits
function automatic logic [127:0] md5_ref(input logic [511:0] blk);
	logic [31:0] a, b, c, d, f, sum, tmp;
	int          i;
	int          g;
	int          s;
	int          shift_amt [0:15] = '{7, 12, 17, 22, 5, 9, 14, 20,
		4, 11, 16, 23, 6, 10, 15, 21};
	a = 32'h67452301;
	b = 32'hefcdab89;
	c = 32'h98badcfe;
	d = 32'h10325476;
	for (i = 0; i < 64; i++) begin
		case (i / 16)
			0: begin
				f = (b & c) | (~b & d);
				g = i;
			end
			1: begin
				f = (d & b) | (~d & c);
				g = (5 * i + 1) % 16;
			end
			2: begin
				f = b ^ c ^ d;
				g = (3 * i + 5) % 16;
			end
			default: begin
				f = c ^ (b | ~d);
				g = (7 * i) % 16;
			end
		endcase
		s   = shift_amt[(i / 16) * 4 + i % 4];
		sum = a + f + MODEL_T[i] + blk[32*g +: 32];
		tmp = d;
		d   = c;
		c   = b;
		b   = b + ((sum << s) | (sum >> (32 - s)));
		a   = tmp;
	end
	return {a + 32'h67452301, b + 32'hefcdab89, c + 32'h98badcfe, d + 32'h10325476};
endfunction

`endif

// File: bench/tb_md5_core.sv
////////////////////////////////////////
// Testbench for the MD5 core
// Known vectors, random blocks with gaps,
// back to back burst, latency checks
////////////////////////////////////////

`timescale 1ns/1ps

module tb_md5_core;

	`include "md5_model.svh"

	localparam int NUM_TESTS   = 14;
	localparam int FIRST_BURST = 10;
	localparam int MAX_GAP     = 3;
	localparam int LATENCY     = 66;
	localparam int DRAIN_LIMIT = 300;

	logic             clk;
	logic             rstb;
	logic             word_valid;
	md5_pkg::word_t   word;
	logic             digest_valid;
	md5_pkg::digest_t digest;

	// Stimulus table
	md5_pkg::block_t  tbl_blk    [NUM_TESTS];
	md5_pkg::digest_t tbl_digest [NUM_TESTS];
	int               tbl_gap    [NUM_TESTS];
	bit               tbl_burst  [NUM_TESTS];
	string            tbl_name   [NUM_TESTS];
	int               tbl_edge   [NUM_TESTS];

	int     exp_q [$];
	int     cyc = 0;
	int     last_valid_edge = 0;
	int     n_pass = 0;
	int     n_fail = 0;
	int     n_err = 0;
	integer seed = 32'hf52b;

	md5_core u_md5_core (
		.clk            (clk),
		.rstb           (rstb),
		.word_valid_i   (word_valid),
		.word_i         (word),
		.digest_valid_o (digest_valid),
		.digest_o       (digest)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	////////////////////////////////////////
	// Table setup
	task automatic build_table();
		int i;
		int w;
		for (i = 0; i < NUM_TESTS; i++) begin
			tbl_blk[i]   = '0;
			tbl_gap[i]   = 0;
			tbl_burst[i] = (i > FIRST_BURST);
		end
		// Empty message and "abc", both padded
		tbl_name[0]              = "empty";
		tbl_blk[0][31:0]         = 32'h00000080;
		tbl_digest[0]            = 128'hd98c1dd4_04b2008f_980980e9_7e42f8ec;
		tbl_name[1]              = "abc";
		tbl_blk[1][31:0]         = 32'h80636261;
		tbl_blk[1][32*14 +: 32]  = 32'd24;
		tbl_digest[1]            = 128'h98500190_b04fd23c_7d3f96d6_727fe128;
		for (i = 2; i < NUM_TESTS; i++) begin
			for (w = 0; w < 16; w++)
				tbl_blk[i][32*w +: 32] = $random(seed);
			tbl_digest[i] = md5_ref(tbl_blk[i]);
			tbl_name[i]   = (i < FIRST_BURST) ? $sformatf("random %0d", i - 2) :
				$sformatf("burst %0d", i - FIRST_BURST);
			tbl_gap[i]    = (i < FIRST_BURST) ? MAX_GAP : 0;
		end
	endtask

	// The model must agree with the two known digests
	task automatic check_model();
		int i;
		for (i = 0; i < 2; i++) begin
			if (md5_ref(tbl_blk[i]) !== tbl_digest[i]) begin
				$display("Mismatch at %0t: model digest = %h, expected %h", $time,
					md5_ref(tbl_blk[i]), tbl_digest[i]);
				n_err++;
			end
		end
	endtask

	////////////////////////////////////////
	// Driving and waiting
	task automatic send_block(input int idx);
		int w;
		int k;
		int gap;
		for (w = 0; w < 16; w++) begin
			gap = 0;
			if (tbl_gap[idx] > 0)
				gap = $unsigned($random(seed)) % (tbl_gap[idx] + 1);
			for (k = 0; k < gap; k++) begin
				@(posedge clk);
				word_valid <= 1'b0;
				word       <= $random(seed);
			end
			@(posedge clk);
			word_valid <= 1'b1;
			word       <= tbl_blk[idx][32*w +: 32];
		end
		// The DUT samples the last word on the next edge
		tbl_edge[idx] = cyc + 1;
		exp_q.push_back(idx);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() > 0) begin
			$display("Timeout: %0d digests still missing after %0d cycles", exp_q.size(),
				DRAIN_LIMIT);
			n_err++;
		end
	endtask

	////////////////////////////////////////
	// Digest monitor
	always @(negedge clk) begin : monitor
		int idx;
		bit ok;
		if (!rstb) begin
			if (digest_valid !== 1'b0) begin
				$display("Mismatch at %0t: digest_valid_o = %b during reset, expected 0",
					$time, digest_valid);
				n_err++;
			end
		end else if (digest_valid) begin
			if (exp_q.size() == 0) begin
				$display("At %0t digest_valid_o rose with no block outstanding", $time);
				n_err++;
			end else begin
				idx = exp_q.pop_front();
				ok  = 1'b1;
				if (digest !== tbl_digest[idx]) begin
					$display("Mismatch at %0t: digest_o = %h, expected %h", $time, digest,
						tbl_digest[idx]);
					ok = 1'b0;
				end
				if (cyc - tbl_edge[idx] != LATENCY) begin
					$display("Mismatch at %0t: digest_valid_o latency = %0d, expected %0d",
						$time, cyc - tbl_edge[idx], LATENCY);
					ok = 1'b0;
				end
				if (tbl_burst[idx] && cyc - last_valid_edge != 16) begin
					$display("Mismatch at %0t: digest_valid_o spacing = %0d, expected 16",
						$time, cyc - last_valid_edge);
					ok = 1'b0;
				end
				last_valid_edge = cyc;
				if (ok)
					n_pass++;
				else
					n_fail++;
				$display("Test %0d %s: %s", idx, tbl_name[idx], ok ? "pass" : "failed");
			end
		end
	end

	initial begin
		int i;
		rstb       = 1'b0;
		word_valid = 1'b0;
		word       = '0;
		build_table();
		check_model();
		repeat (3) @(posedge clk);
		rstb <= 1'b1;
		repeat (4) @(posedge clk);

		for (i = 0; i < FIRST_BURST; i++)
			send_block(i);
		@(posedge clk);
		word_valid <= 1'b0;
		wait_drain();

		// Four blocks back to back fill all four rounds
		for (i = FIRST_BURST; i < NUM_TESTS; i++)
			send_block(i);
		if (exp_q.size() != 4) begin
			$display("Only %0d blocks in flight after the burst, expected 4", exp_q.size());
			n_err++;
		end
		@(posedge clk);
		word_valid <= 1'b0;
		wait_drain();
		repeat (20) @(posedge clk);

		$display("Summary: %0d tests passed, %0d failed, %0d other errors", n_pass, n_fail,
			n_err);
		if (n_pass == NUM_TESTS && n_fail == 0 && n_err == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: hw/md5_core.sv
////////////////////////////////////////
// MD5 core top level
// Loader, four round engines, digest adder
////////////////////////////////////////

`timescale 1ns/1ps

module md5_core (
	input  logic              clk,
	input  logic              rstb,
	input  logic              word_valid_i,
	input  md5_pkg::word_t    word_i,
	output logic              digest_valid_o,
	output md5_pkg::digest_t  digest_o
);

	// Link n feeds round n, the last one feeds the adder
	md5_stage_if stage_if [0:md5_pkg::NUM_ROUNDS] ();

	md5_block_loader u_loader (
		.clk          (clk),
		.rstb         (rstb),
		.word_valid_i (word_valid_i),
		.word_i       (word_i),
		.stage_o      (stage_if[0])
	);

	for (genvar n = 0; n < md5_pkg::NUM_ROUNDS; n++) begin : g_round
		md5_round #(
			.ROUND_IDX (n)
		) u_round (
			.clk     (clk),
			.rstb    (rstb),
			.stage_i (stage_if[n]),
			.stage_o (stage_if[n+1])
		);
	end

	md5_digest_adder u_adder (
		.clk            (clk),
		.rstb           (rstb),
		.stage_i        (stage_if[md5_pkg::NUM_ROUNDS]),
		.digest_valid_o (digest_valid_o),
		.digest_o       (digest_o)
	);

endmodule

// File: hw/md5_digest_adder.sv
////////////////////////////////////////
// Digest adder
// Final state plus initial value, registered
////////////////////////////////////////

`timescale 1ns/1ps

module md5_digest_adder (
	input  logic              clk,
	input  logic              rstb,
	md5_stage_if.dst          stage_i,
	output logic              digest_valid_o,
	output md5_pkg::digest_t  digest_o
);

	logic             valid_q;
	md5_pkg::digest_t digest_q;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb)
			valid_q <= 1'b0;
		else
			valid_q <= stage_i.go;
	end

	// A in the top word, held until the next block
	always_ff @(posedge clk) begin
		if (stage_i.go)
			digest_q <= {stage_i.a + md5_pkg::IV_A, stage_i.b + md5_pkg::IV_B,
				stage_i.c + md5_pkg::IV_C, stage_i.d + md5_pkg::IV_D};
	end

	assign digest_valid_o = valid_q;
	assign digest_o       = digest_q;

endmodule

// File: hw/md5_round.sv
////////////////////////////////////////
// Round engine
// Sixteen MD5 steps of one round on a captured block
////////////////////////////////////////

`timescale 1ns/1ps

module md5_round #(
	parameter int ROUND_IDX = 0
) (
	input  logic     clk,
	input  logic     rstb,
	md5_stage_if.dst stage_i,
	md5_stage_if.src stage_o
);

	typedef enum logic {ST_IDLE, ST_RUN} state_e;

	state_e            state;
	md5_pkg::rstep_t   cnt;
	logic              go_q;
	md5_pkg::block_t   blk_q;
	md5_pkg::word_t    a_q, b_q, c_q, d_q;

	md5_pkg::block_t   src_blk;
	md5_pkg::word_t    src_a, src_b, src_c, src_d;
	md5_pkg::step_t    step_idx;
	md5_pkg::widx_t    k;
	md5_pkg::shift_t   s;
	md5_pkg::word_t    sum, rot;

	////////////////////////////////////////
	// Step datapath
	// Step 0 works straight from the incoming stage
	always_comb begin
		src_blk = stage_i.go ? stage_i.blk : blk_q;
		src_a   = stage_i.go ? stage_i.a : a_q;
		src_b   = stage_i.go ? stage_i.b : b_q;
		src_c   = stage_i.go ? stage_i.c : c_q;
		src_d   = stage_i.go ? stage_i.d : d_q;

		// cnt rests at zero while idle
		step_idx = md5_pkg::step_t'(ROUND_IDX * md5_pkg::STEPS_PER_ROUND) +
			md5_pkg::step_t'(cnt);
		k = md5_pkg::K_TABLE[step_idx];
		s = md5_pkg::S_TABLE[step_idx];

		sum = src_a + md5_pkg::md5_func(2'(ROUND_IDX), src_b, src_c, src_d) +
			src_blk[32*k +: 32] + md5_pkg::T_TABLE[step_idx];
		rot = (sum << s) | (sum >> (6'd32 - {1'b0, s}));
	end

	////////////////////////////////////////
	// Control
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= ST_IDLE;
			cnt   <= '0;
			go_q  <= 1'b0;
		end else begin
			go_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (stage_i.go) begin
						state <= ST_RUN;
						cnt   <= cnt + 1'b1;
					end
				end
				ST_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == md5_pkg::rstep_t'(md5_pkg::STEPS_PER_ROUND - 1)) begin
						state <= ST_IDLE;
						go_q  <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Working state, rotated by one word every step
	always_ff @(posedge clk) begin
		if (stage_i.go)
			blk_q <= stage_i.blk;
		if (stage_i.go || state == ST_RUN) begin
			a_q <= src_d;
			b_q <= src_b + rot;
			c_q <= src_b;
			d_q <= src_c;
		end
	end

	assign stage_o.go  = go_q;
	assign stage_o.a   = a_q;
	assign stage_o.b   = b_q;
	assign stage_o.c   = c_q;
	assign stage_o.d   = d_q;
	assign stage_o.blk = blk_q;

	// Upstream spacing must match the 16 cycle occupancy
	a_no_overrun: assert property (@(posedge clk) disable iff (!rstb)
		stage_i.go |-> state == ST_IDLE);

	a_go_pulse: assert property (@(posedge clk) disable iff (!rstb)
		stage_o.go |=> !stage_o.go);

endmodule

// File: hw/md5_block_loader.sv
////////////////////////////////////////
// Block loader
// Gathers sixteen words and launches round 0
////////////////////////////////////////

`timescale 1ns/1ps

module md5_block_loader (
	input  logic            clk,
	input  logic            rstb,
	input  logic            word_valid_i,
	input  md5_pkg::word_t  word_i,
	md5_stage_if.src        stage_o
);

	md5_pkg::widx_t  cnt;
	md5_pkg::block_t blk_q;
	logic            go_q;
	logic            last_word;

	assign last_word = word_valid_i &&
		(cnt == md5_pkg::widx_t'(md5_pkg::WORDS_PER_BLOCK - 1));

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cnt  <= '0;
			go_q <= 1'b0;
		end else begin
			go_q <= last_word;
			// Wraps to zero after the last word
			if (word_valid_i)
				cnt <= cnt + 1'b1;
		end
	end

	// New words enter at the top so word 0 ends up in the low bits
	always_ff @(posedge clk) begin
		if (word_valid_i)
			blk_q <= {word_i, blk_q[511:32]};
	end

	assign stage_o.go  = go_q;
	assign stage_o.blk = blk_q;
	assign stage_o.a   = md5_pkg::IV_A;
	assign stage_o.b   = md5_pkg::IV_B;
	assign stage_o.c   = md5_pkg::IV_C;
	assign stage_o.d   = md5_pkg::IV_D;

	a_go_after_wrap: assert property (@(posedge clk) disable iff (!rstb)
		stage_o.go |-> cnt == '0);

endmodule

// File: hw/md5_stage_if.sv
////////////////////////////////////////
// Stage link between MD5 pipeline blocks
////////////////////////////////////////

`timescale 1ns/1ps

interface md5_stage_if;

	// Valid for the single cycle in which go is high
	logic              go;
	md5_pkg::word_t    a;
	md5_pkg::word_t    b;
	md5_pkg::word_t    c;
	md5_pkg::word_t    d;
	md5_pkg::block_t   blk;

	modport src (output go, a, b, c, d, blk);
	modport dst (input go, a, b, c, d, blk);

endinterface

// File: hw/md5_pkg.sv
////////////////////////////////////////
// MD5 shared definitions
// Word, step and block types, initial value,
// T, shift and index tables, round functions
////////////////////////////////////////

package md5_pkg;

	typedef logic [31:0]  word_t;
	typedef logic [5:0]   step_t;
	typedef logic [3:0]   rstep_t;
	typedef logic [4:0]   shift_t;
	typedef logic [3:0]   widx_t;
	typedef logic [511:0] block_t;
	typedef logic [127:0] digest_t;

	localparam int WORDS_PER_BLOCK = 16;
	localparam int STEPS_PER_ROUND = 16;
	localparam int NUM_ROUNDS      = 4;

	localparam word_t IV_A = 32'h67452301;
	localparam word_t IV_B = 32'hefcdab89;
	localparam word_t IV_C = 32'h98badcfe;
	localparam word_t IV_D = 32'h10325476;

	////////////////////////////////////////
	// Sine constants
	localparam word_t T_TABLE [0:63] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// Rotate amounts, four per round repeated
	localparam shift_t S_TABLE [0:63] = '{
		5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
		5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9,  5'd14, 5'd20, 5'd5, 5'd9,  5'd14, 5'd20,
		5'd5, 5'd9,  5'd14, 5'd20, 5'd5, 5'd9,  5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
		5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21,
		5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21
	};

	// Message word used by each step
	localparam widx_t K_TABLE [0:63] = '{
		4'd0,  4'd1,  4'd2,  4'd3,  4'd4,  4'd5,  4'd6,  4'd7,
		4'd8,  4'd9,  4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15,
		4'd1,  4'd6,  4'd11, 4'd0,  4'd5,  4'd10, 4'd15, 4'd4,
		4'd9,  4'd14, 4'd3,  4'd8,  4'd13, 4'd2,  4'd7,  4'd12,
		4'd5,  4'd8,  4'd11, 4'd14, 4'd1,  4'd4,  4'd7,  4'd10,
		4'd13, 4'd0,  4'd3,  4'd6,  4'd9,  4'd12, 4'd15, 4'd2,
		4'd0,  4'd7,  4'd14, 4'd5,  4'd12, 4'd3,  4'd10, 4'd1,
		4'd8,  4'd15, 4'd6,  4'd13, 4'd4,  4'd11, 4'd2,  4'd9
	};

	// F, G, H and I selected by round number
	function automatic word_t md5_func(input logic [1:0] rnd, input word_t b,
			input word_t c, input word_t d);
		case (rnd)
			2'd0:    return (b & c) | (~b & d);
			2'd1:    return (b & d) | (c & ~d);
			2'd2:    return b ^ c ^ d;
			default: return c ^ (b | ~d);
		endcase
	endfunction

endpackage
